// ==== design/display_pkg.sv ====
// ==========================================================================
// raster types shared by timing, sprite engines and top
// coordinates are signed, blanking sits at negative positions
// ==========================================================================

package display_pkg;

    localparam int CORDW = 16;  // raster coordinate width

    // signed screen coordinate, active area starts at 0
    typedef logic signed [CORDW-1:0] coord_t;

    // 4 bits per channel, matches the VGA DAC
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } colour_t;

endpackage

// ==== design/sprite_pkg.sv ====
// ==========================================================================
// sprite register map, descriptor layout and glyph geometry
// addresses are Wishbone word addresses, 8 bits wide
// ==========================================================================

package sprite_pkg;

    localparam int SPR_CNT   = 4;   // sprites on screen
    localparam int SPR_AW    = $clog2(SPR_CNT);
    localparam int GLYPH_W   = 8;   // pixels per glyph row
    localparam int GLYPH_H   = 8;   // rows per glyph
    localparam int GLYPH_CNT = 16;
    localparam int GLYPH_RW  = $clog2(GLYPH_H);             // row select width
    localparam int GLYPH_AW  = $clog2(GLYPH_CNT * GLYPH_H); // 128 rows

    typedef logic [3:0]         glyph_idx_t;
    typedef logic [GLYPH_W-1:0] glyph_row_t;  // msb is the leftmost pixel

    // x in the low bits so a plain word write reads naturally
    typedef struct packed {
        logic [3:0]  rsvd;
        glyph_idx_t  glyph;
        logic [11:0] y;
        logic [11:0] x;
    } spr_desc_t;

    // register map
    localparam logic [7:0] REG_CTRL     = 8'h00;
    localparam logic [7:0] REG_COLOUR   = 8'h01;
    localparam logic [7:0] REG_SPR_BASE = 8'h04;  // + sprite number
    localparam logic [7:0] GLYPH_BASE   = 8'h40;  // + glyph*8 + row

    // control word, bits SPR_CNT-1:0 are the sprite enable mask
    localparam int CTRL_STAR_BIT = 4;  // starfield enable
    localparam int CTRL_W        = 5;

endpackage

// ==== design/sprite_cfg_if.sv ====
// ==========================================================================
// config bundle from register block to sprite engines
// engines each drive their own address slot, the top ORs them together
// ==========================================================================
`timescale 1ns/1ps

interface sprite_cfg_if import display_pkg::*, sprite_pkg::*; ();

    spr_desc_t            desc [SPR_CNT];
    logic [SPR_CNT-1:0]   spr_en;
    colour_t              colour;
    logic                 star_en;
    glyph_row_t           glyph_rdata;   // one cycle after glyph_raddr
    logic [GLYPH_AW-1:0]  glyph_raddr;   // merged address
    wire  [GLYPH_AW-1:0]  eng_raddr [SPR_CNT];  // per engine, zero outside slot

    modport regs (
        output desc, spr_en, colour, star_en, glyph_rdata,
        input  glyph_raddr
    );

    modport eng (
        input  desc, spr_en, glyph_rdata,
        output eng_raddr
    );

endinterface

// ==== design/display_timings.sv ====
// ==========================================================================
// raster counters, sync active low; all outputs registered and aligned
// horizontal blanking must be at least 2*SPR_CNT cycles for glyph fetch
// ==========================================================================
`timescale 1ns/1ps

module display_timings import display_pkg::*; #(
    parameter int H_RES  = 640,
    parameter int V_RES  = 480,
    parameter int H_FP   = 16,
    parameter int H_SYNC = 96,
    parameter int H_BP   = 48,
    parameter int V_FP   = 10,
    parameter int V_SYNC = 2,
    parameter int V_BP   = 33
) (
    input  logic   clk_pix,
    input  logic   rst_n,
    output coord_t sx,
    output coord_t sy,
    output logic   hsync,
    output logic   vsync,
    output logic   de,
    output logic   line
);

    // blanking starts negative so the active area begins at 0
    localparam coord_t H_STA  = coord_t'(-H_FP - H_SYNC - H_BP);
    localparam coord_t HS_STA = coord_t'(-H_SYNC - H_BP);
    localparam coord_t HS_END = coord_t'(-H_BP);
    localparam coord_t HA_END = coord_t'(H_RES - 1);
    localparam coord_t V_STA  = coord_t'(-V_FP - V_SYNC - V_BP);
    localparam coord_t VS_STA = coord_t'(-V_SYNC - V_BP);
    localparam coord_t VS_END = coord_t'(-V_BP);
    localparam coord_t VA_END = coord_t'(V_RES - 1);

    coord_t sx_n, sy_n;  // next position

    always_comb begin
        sx_n = sx + coord_t'(1);
        sy_n = sy;
        if (sx == HA_END) begin  // end of line, wrap into blanking
            sx_n = H_STA;
            sy_n = (sy == VA_END) ? V_STA : sy + coord_t'(1);
        end
    end

    // flags come from the next position so they line up with sx/sy
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sx    <= HA_END;  // first step lands on frame start
            sy    <= VA_END;
            hsync <= 1'b1;
            vsync <= 1'b1;
            de    <= 1'b0;
            line  <= 1'b0;
        end else begin
            sx    <= sx_n;
            sy    <= sy_n;
            hsync <= !(sx_n >= HS_STA && sx_n < HS_END);
            vsync <= !(sy_n >= VS_STA && sy_n < VS_END);
            de    <= (sx_n >= 0) && (sy_n >= 0);
            line  <= (sx_n == H_STA);  // first blanking pixel
        end
    end

    // engines rely on one line pulse per line, right after the last active pixel
    assert property (@(posedge clk_pix) disable iff (!rst_n)
        line |-> ($past(sx) == HA_END) ##1 !line);

endmodule

// ==== design/sprite_regs.sv ====
// ==========================================================================
// Wishbone classic slave, one-cycle ack, unmapped words ack and read 0
// glyph memory has a bus port and a registered display read port
// ==========================================================================
`timescale 1ns/1ps

module sprite_regs import display_pkg::*, sprite_pkg::*; (
    input  logic        clk_pix,
    input  logic        rst_n,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [7:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    sprite_cfg_if.regs  cfg
);

    localparam int GLYPH_ROWS = GLYPH_CNT * GLYPH_H;

    logic [CTRL_W-1:0]   ctrl;
    colour_t             colour;
    spr_desc_t           desc [SPR_CNT];
    glyph_row_t          glyph_mem [GLYPH_ROWS];

    logic                req;  // first cycle of a bus access
    logic                hit_ctrl, hit_col, hit_spr, hit_glyph;
    logic [SPR_AW-1:0]   spr_a;
    logic [GLYPH_AW-1:0] glyph_a;
    logic [31:0]         rd_word;

    assign req = wb_cyc && wb_stb && !wb_ack;

    // address decode
    always_comb begin
        hit_ctrl  = (wb_adr == REG_CTRL);
        hit_col   = (wb_adr == REG_COLOUR);
        hit_spr   = (wb_adr[7:SPR_AW] == REG_SPR_BASE[7:SPR_AW]);
        hit_glyph = (wb_adr >= GLYPH_BASE) && (wb_adr < GLYPH_BASE + 8'(GLYPH_ROWS));
        spr_a     = wb_adr[SPR_AW-1:0];  // base is aligned
        glyph_a   = GLYPH_AW'(wb_adr - GLYPH_BASE);
    end

    always_comb begin
        rd_word = '0;  // unmapped reads zero
        if (hit_ctrl)       rd_word = 32'(ctrl);
        else if (hit_col)   rd_word = 32'(colour);
        else if (hit_spr)   rd_word = desc[spr_a];
        else if (hit_glyph) rd_word = 32'(glyph_mem[glyph_a]);
    end

    // control registers, written on the ack edge
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
            ctrl   <= '0;
            colour <= '0;
            for (int i = 0; i < SPR_CNT; i++) desc[i] <= '0;
        end else begin
            wb_ack <= req;  // drops next cycle even if stb stays high
            if (req && wb_we) begin
                if (hit_ctrl) ctrl <= wb_dat_w[CTRL_W-1:0];
                if (hit_col)  colour <= colour_t'(wb_dat_w[11:0]);
                if (hit_spr)  desc[spr_a] <= spr_desc_t'(wb_dat_w);
            end
        end
    end

    // glyph rows and bus read data
    always_ff @(posedge clk_pix) begin
        if (req) begin
            if (wb_we && hit_glyph) glyph_mem[glyph_a] <= wb_dat_w[GLYPH_W-1:0];
            wb_dat_r <= rd_word;  // valid with ack
        end
    end

    // display port, data one cycle after the engine's slot
    always_ff @(posedge clk_pix) begin
        cfg.glyph_rdata <= glyph_mem[cfg.glyph_raddr];
    end

    assign cfg.desc    = desc;
    assign cfg.spr_en  = ctrl[SPR_CNT-1:0];
    assign cfg.star_en = ctrl[CTRL_STAR_BIT];
    assign cfg.colour  = colour;

    // ack only meets a master still holding its request, and is a single pulse
    assert property (@(posedge clk_pix) disable iff (!rst_n)
        wb_ack |-> (wb_cyc && wb_stb));
    assert property (@(posedge clk_pix) disable iff (!rst_n)
        wb_ack |=> !wb_ack);

endmodule

// ==== design/sprite_engine.sv ====
// ==========================================================================
// one scaled glyph sprite; SCALE must be a power of two
// row fetched in blanking slot ID - 2*SPR_CNT, drawn on the same line
// ==========================================================================
`timescale 1ns/1ps

module sprite_engine import display_pkg::*, sprite_pkg::*; #(
    parameter int ID    = 0,
    parameter int SCALE = 8
) (
    input  logic      clk_pix,
    input  logic      rst_n,
    input  coord_t    sx,
    input  coord_t    sy,
    input  logic      line,
    sprite_cfg_if.eng cfg,
    output logic      pix
);

    localparam int     SHIFT = $clog2(SCALE);
    localparam coord_t SPAN  = coord_t'(GLYPH_W * SCALE);  // screen size
    localparam coord_t SLOT  = coord_t'(ID - 2 * SPR_CNT);  // fetch cycle

    coord_t                 spr_x, spr_y, dy, start_x;
    logic                   band;      // this line crosses the sprite
    logic [GLYPH_RW-1:0]    row_sel;
    glyph_row_t             row_data;  // fetched row
    glyph_row_t             shreg;     // row being drawn
    logic [SHIFT:0]         sub;       // pixels within one glyph bit
    logic [$clog2(GLYPH_W+1)-1:0] bits_left;
    logic [GLYPH_AW-1:0]    raddr;

    assign spr_x   = coord_t'(cfg.desc[ID].x);
    assign spr_y   = coord_t'(cfg.desc[ID].y);
    assign dy      = sy - spr_y;
    assign start_x = spr_x - coord_t'(1);  // load one pixel early

    // own the read port only in our slot
    assign raddr = (sx == SLOT) ? {cfg.desc[ID].glyph, row_sel} : '0;
    assign cfg.eng_raddr[ID] = raddr;

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            band      <= 1'b0;
            row_sel   <= '0;
            sub       <= '0;
            bits_left <= '0;
        end else begin
            if (line) begin  // vertical band check
                band    <= !dy[CORDW-1] && (dy < SPAN);
                row_sel <= dy[SHIFT +: GLYPH_RW];
            end
            if (sx == start_x) begin
                sub       <= '0;
                bits_left <= GLYPH_W[$bits(bits_left)-1:0];
            end else if (bits_left != 0) begin
                if (sub == (SHIFT+1)'(SCALE - 1)) begin
                    sub       <= '0;
                    bits_left <= bits_left - 1'b1;
                end else begin
                    sub <= sub + 1'b1;
                end
            end
        end
    end

    // row capture and shift out, msb first
    always_ff @(posedge clk_pix) begin
        if (sx == SLOT + coord_t'(1)) row_data <= band ? cfg.glyph_rdata : '0;
        if (sx == start_x)
            shreg <= row_data;
        else if (bits_left != 0 && sub == (SHIFT+1)'(SCALE - 1))
            shreg <= shreg << 1;
    end

    assign pix = cfg.spr_en[ID] && (bits_left != 0) && shreg[GLYPH_W-1];

    // line pulse lands before our slot, so the slot address uses this line's row
    assert property (@(posedge clk_pix) disable iff (!rst_n)
        line |-> (sx < SLOT));

endmodule

// ==== design/starfield.sv ====
// ==========================================================================
// 21-bit Galois LFSR stars; FRAME_LEN is the full frame in pixels
// negative INC shortens the period so the field drifts each frame
// ==========================================================================
`timescale 1ns/1ps

module starfield #(
    parameter int          INC       = -1,
    parameter logic [20:0] SEED      = 21'h1FFFFF,
    parameter logic [20:0] MASK      = 21'hFFF,  // set bits are ignored
    parameter int          FRAME_LEN = 800 * 525
) (
    input  logic       clk_pix,
    input  logic       rst_n,
    input  logic       en,
    output logic       star_on,
    output logic [3:0] star_lvl
);

    localparam logic [20:0] TAPS    = 21'h140000;  // x^21 + x^19 + 1
    localparam logic [20:0] RST_CNT = 21'(FRAME_LEN + INC - 1);

    logic [20:0] lfsr;
    logic [20:0] cnt;  // pixels since restart

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            lfsr <= SEED;
            cnt  <= '0;
        end else if (en) begin
            cnt  <= (cnt == RST_CNT) ? '0 : cnt + 1'b1;
            lfsr <= (cnt == RST_CNT) ? SEED
                  : {1'b0, lfsr[20:1]} ^ (lfsr[0] ? TAPS : '0);
        end
    end

    assign star_on  = en && &(lfsr | MASK);  // fewer mask bits, fewer stars
    assign star_lvl = lfsr[7:4];

endmodule

// ==== design/hello_display_top.sv ====
// ==========================================================================
// sprite display top: clk_pix and rst_n come from outside, no clock gen
// VGA outputs registered one cycle after the raster signals
// ==========================================================================
`timescale 1ns/1ps

module hello_display_top import display_pkg::*, sprite_pkg::*; #(
    parameter int H_RES  = 640,
    parameter int V_RES  = 480,
    parameter int H_FP   = 16,
    parameter int H_SYNC = 96,
    parameter int H_BP   = 48,
    parameter int V_FP   = 10,
    parameter int V_SYNC = 2,
    parameter int V_BP   = 33,
    parameter int SCALE  = 8
) (
    input  logic        clk_pix,
    input  logic        rst_n,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [7:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    output logic        vga_hsync,
    output logic        vga_vsync,
    output logic [3:0]  vga_r,
    output logic [3:0]  vga_g,
    output logic [3:0]  vga_b
);

    localparam int FRAME_LEN = (H_RES + H_FP + H_SYNC + H_BP) * (V_RES + V_FP + V_SYNC + V_BP);

    coord_t             sx, sy;
    logic               hsync, vsync, de, line;
    logic [SPR_CNT-1:0] spr_pix;
    logic [2:0]         sf_on;
    logic [3:0]         sf_lvl [3];
    logic [3:0]         star_lvl;  // brightest lit layer
    colour_t            pix_c;

    sprite_cfg_if cfg ();

    display_timings #(
        .H_RES(H_RES), .V_RES(V_RES), .H_FP(H_FP), .H_SYNC(H_SYNC),
        .H_BP(H_BP), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) display_timings_i (
        .clk_pix, .rst_n, .sx, .sy, .hsync, .vsync, .de, .line
    );

    sprite_regs sprite_regs_i (
        .clk_pix, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr,
        .wb_dat_w, .wb_dat_r, .wb_ack, .cfg(cfg.regs)
    );

    for (genvar k = 0; k < SPR_CNT; k++) begin : g_spr
        sprite_engine #(.ID(k), .SCALE(SCALE)) sprite_engine_i (
            .clk_pix, .rst_n, .sx, .sy, .line, .cfg(cfg.eng), .pix(spr_pix[k])
        );
    end

    // slots never overlap, so OR is a clean merge
    always_comb begin
        cfg.glyph_raddr = '0;
        for (int k = 0; k < SPR_CNT; k++) cfg.glyph_raddr |= cfg.eng_raddr[k];
    end

    starfield #(.INC(-1), .SEED(21'h9A9A9), .FRAME_LEN(FRAME_LEN)) starfield_0_i (
        .clk_pix, .rst_n, .en(cfg.star_en), .star_on(sf_on[0]), .star_lvl(sf_lvl[0])
    );
    starfield #(.INC(-2), .SEED(21'hA9A9A), .FRAME_LEN(FRAME_LEN)) starfield_1_i (
        .clk_pix, .rst_n, .en(cfg.star_en), .star_on(sf_on[1]), .star_lvl(sf_lvl[1])
    );
    starfield #(.INC(-4), .MASK(21'h7FF), .FRAME_LEN(FRAME_LEN)) starfield_2_i (
        .clk_pix, .rst_n, .en(cfg.star_en), .star_on(sf_on[2]), .star_lvl(sf_lvl[2])
    );

    always_comb begin
        star_lvl = '0;
        for (int k = 0; k < 3; k++)
            if (sf_on[k] && sf_lvl[k] > star_lvl) star_lvl = sf_lvl[k];
    end

    // sprites over stars, black outside the active area
    always_comb begin
        if (!de)            pix_c = '0;
        else if (|spr_pix)  pix_c = cfg.colour;
        else if (|sf_on)    pix_c = '{r: star_lvl, g: star_lvl, b: star_lvl};
        else                pix_c = '0;
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            vga_hsync <= 1'b1;  // inactive
            vga_vsync <= 1'b1;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
        end else begin
            vga_hsync <= hsync;
            vga_vsync <= vsync;
            vga_r     <= pix_c.r;
            vga_g     <= pix_c.g;
            vga_b     <= pix_c.b;
        end
    end

endmodule

// ==== dv/hello_display_tb.sv ====
// ==========================================================================
// trace testbench on a 64x48 raster with SCALE 2, commands from the trace
// pixel and frame checks wait for the next rising edge of vga_vsync
// ==========================================================================
`timescale 1ns/1ps

module hello_display_tb import display_pkg::*; ();

    // small raster, blanking still wide enough for the 8 fetch slots
    localparam int H_RES     = 64;
    localparam int V_RES     = 48;
    localparam int H_FP      = 4;
    localparam int H_SYNC    = 8;
    localparam int H_BP      = 4;
    localparam int V_FP      = 2;
    localparam int V_SYNC    = 2;
    localparam int V_BP      = 2;
    localparam int SCALE     = 2;
    localparam int H_BLANK   = H_FP + H_SYNC + H_BP;
    localparam int V_BLANK   = V_FP + V_SYNC + V_BP;
    localparam int FRAME_CYC = (H_RES + H_BLANK) * (V_RES + V_BLANK);

    logic        clk_pix;
    logic        rst_n;
    logic        wb_cyc, wb_stb, wb_we;
    logic [7:0]  wb_adr;
    logic [31:0] wb_dat_w, wb_dat_r;
    logic        wb_ack;
    logic        vga_hsync, vga_vsync;
    logic [3:0]  vga_r, vga_g, vga_b;

    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          cycles = 0;
    int          cycle_limit = 0;  // armed once the trace is loaded
    logic [31:0] lfsr_state = 32'h1eb5_3936;

    byte         cmd_q [$];  // one entry per trace command
    logic [31:0] arg_a [$];
    logic [31:0] arg_b [$];
    logic [31:0] arg_c [$];

    hello_display_top #(
        .H_RES(H_RES), .V_RES(V_RES), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP), .SCALE(SCALE)
    ) hello_display_top_i (
        .clk_pix, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
        .wb_dat_r, .wb_ack, .vga_hsync, .vga_vsync, .vga_r, .vga_g, .vga_b
    );

    initial begin
        clk_pix = 1'b0;
        forever #4 clk_pix = ~clk_pix;  // 8 ns period
    end

    always @(posedge clk_pix) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout: run still busy after %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1, new bit enters at bit 0
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);  // one step per bit
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %08h expected %08h", name, got, exp);
        end
    endtask

    task automatic check_colour(input string name, input colour_t got, input colour_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %03h expected %03h", name, got, exp);
        end
    endtask

    task automatic check_sync(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
        end
    endtask

    // classic cycle, master holds cyc/stb until ack
    task automatic bus_access(input logic we, input logic [7:0] adr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited = 0;
        @(posedge clk_pix);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        do begin
            @(negedge clk_pix);
            waited++;
        end while (!wb_ack && waited < 16);
        if (!wb_ack) begin
            errors++;
            $display("bus access to %02h got no ack within 16 cycles", adr);
        end
        rdata = wb_dat_r;  // valid with ack
        @(posedge clk_pix);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(negedge clk_pix);
        if (wb_ack) begin
            errors++;
            $display("ack for bus access to %02h lasted more than one cycle", adr);
        end
    endtask

    // the rising sample shows the first blanking pixel of line -V_BP
    task automatic find_frame_start(output int x, output int y);
        logic prev;
        @(negedge clk_pix);
        do begin
            prev = vga_vsync;
            @(negedge clk_pix);
        end while (prev || !vga_vsync);
        x = -H_BLANK;
        y = -V_BP;
    endtask

    task automatic step_pixel(inout int x, inout int y);
        @(negedge clk_pix);
        x++;
        if (x == H_RES) begin  // wrap into next line's blanking
            x = -H_BLANK;
            y++;
            if (y == V_RES) y = -V_BLANK;
        end
    endtask

    task automatic pixel_test(input int px, input int py, input colour_t exp);
        int x;
        int y;
        find_frame_start(x, y);
        while (x != px || y != py) step_pixel(x, y);
        check_colour($sformatf("vga rgb at (%0d,%0d)", px, py), {vga_r, vga_g, vga_b}, exp);
    endtask

    // one whole frame: sync per pixel, black blanking, grey stars if enabled
    task automatic frame_test(input logic stars, output int lit);
        int    x;
        int    y;
        logic  hs_exp, vs_exp;
        string at;
        lit = 0;
        find_frame_start(x, y);
        for (int n = 0; n < FRAME_CYC; n++) begin
            if (n > 0) step_pixel(x, y);
            at     = $sformatf(" at (%0d,%0d)", x, y);
            hs_exp = !(x >= -(H_SYNC + H_BP) && x < -H_BP);  // active low
            vs_exp = !(y >= -(V_SYNC + V_BP) && y < -V_BP);
            check_sync({"vga_hsync", at}, vga_hsync, hs_exp);
            check_sync({"vga_vsync", at}, vga_vsync, vs_exp);
            if (stars && x >= 0 && y >= 0) begin
                checks++;
                if (vga_r != vga_g || vga_g != vga_b) begin
                    errors++;
                    $display("star pixel%s is not grey: r %h g %h b %h",
                             at, vga_r, vga_g, vga_b);
                end
                if (vga_r != 4'h0) lit++;
            end else begin
                check_colour({"vga rgb", at}, {vga_r, vga_g, vga_b}, '0);
            end
        end
        if (stars) begin  // three layers give a dozen or so stars a frame
            checks++;
            if (lit == 0) begin
                errors++;
                $display("no star pixel lit in a whole frame with stars enabled");
            end
        end
    endtask

    // random rows into spare glyphs, then read all of them back
    task automatic glyph_fill_test(input logic [7:0] base, input int count);
        logic [31:0] vals [$];
        logic [31:0] v;
        logic [31:0] rd;
        for (int i = 0; i < count; i++) begin
            random_bits(8, v);
            vals.push_back(v);
            bus_access(1'b1, base + 8'(i), v, rd);
        end
        for (int i = 0; i < count; i++) begin
            bus_access(1'b0, base + 8'(i), '0, rd);
            check_word($sformatf("wb_dat_r @%02h", base + 8'(i)), rd, vals[i]);
        end
    endtask

    task automatic report_test(input string name, input int err0, input string detail);
        tests++;
        $display("test %0d %s: %s %s", tests, name, (errors == err0) ? "ok" : "error", detail);
    endtask

    task automatic reset_test();
        int err0;
        err0 = errors;
        @(posedge clk_pix);  // first reset cycle
        for (int k = 0; k < 2; k++) begin
            @(negedge clk_pix);  // during reset, then just after release
            check_sync("vga_hsync", vga_hsync, 1'b1);
            check_sync("vga_vsync", vga_vsync, 1'b1);
            check_colour("vga rgb", {vga_r, vga_g, vga_b}, '0);
            check_word("wb_ack", {31'b0, wb_ack}, '0);
            @(posedge clk_pix);
            rst_n <= 1'b1;  // second rising edge ends reset
        end
        report_test("reset", err0, "");
    endtask

    task automatic load_trace();
        int          fd;
        int          n;
        string       text;
        logic [31:0] a, b, c;
        fd = $fopen("dv/display_trace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open dv/display_trace.txt");
            return;
        end
        while (!$feof(fd)) begin
            text = "";
            n = $fgets(text, fd);
            if (n > 0 && text.len() > 2 && text[0] != "#") begin
                a = '0;
                b = '0;
                c = '0;
                n = $sscanf(text.substr(2, text.len() - 1), "%h %h %h", a, b, c);
                cmd_q.push_back(text[0]);
                arg_a.push_back(a);
                arg_b.push_back(b);
                arg_c.push_back(c);
            end
        end
        $fclose(fd);
    endtask

    // pixel and frame checks may first spend a frame finding the start
    function automatic int timeout_cycles();
        int frames;
        int bus;
        frames = 0;
        bus = 100;  // reset and idle slack
        foreach (cmd_q[i]) begin
            if (cmd_q[i] == "P" || cmd_q[i] == "S") frames += 2;
            else if (cmd_q[i] == "X") bus += 12 * int'(arg_b[i]);
            else bus += 6;
        end
        return frames * (FRAME_CYC + 1) + bus + 1000;
    endfunction

    task automatic run_command(input byte cmd, input logic [31:0] a,
                               input logic [31:0] b, input logic [31:0] c);
        int          err0;
        int          lit;
        logic [31:0] rd;
        string       detail;
        err0 = errors;
        detail = "";
        case (cmd)
            "W": bus_access(1'b1, a[7:0], b, rd);
            "R": begin
                bus_access(1'b0, a[7:0], '0, rd);
                check_word($sformatf("wb_dat_r @%02h", a[7:0]), rd, b);
            end
            "P": pixel_test(int'(a), int'(b), colour_t'(c[11:0]));
            "S": begin
                frame_test(a[0], lit);
                detail = $sformatf("(%0d lit star pixels)", lit);
            end
            "X": glyph_fill_test(a[7:0], int'(b));
            default: begin
                errors++;
                $display("unknown trace command %c", cmd);
            end
        endcase
        if (cmd != "W") report_test($sformatf("%c %0h %0h %0h", cmd, a, b, c), err0, detail);
    endtask

    initial begin
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        load_trace();
        cycle_limit = timeout_cycles();
        reset_test();
        foreach (cmd_q[i]) run_command(cmd_q[i], arg_a[i], arg_b[i], arg_c[i]);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0 && tests > 1) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== dv/display_trace.txt ====
# W addr data | R addr expected | P x y rgb | S stars_on | X addr count
# all fields hex, addresses are bus word addresses, rgb is r g b nibbles
W 01 00000f80
# glyph 1, rows at 0x48..0x4f
W 48 000000c0
W 49 00000081
W 4a 0000003c
W 4b 000000ff
W 4c 00000001
W 4d 00000018
W 4e 00000080
W 4f 00000000
# sprites 0..3 all show glyph 1, sprite 3 overlaps sprite 1
W 04 01002004
W 05 0101401e
W 06 0100a028
W 07 01014024
W 00 0000000b
R 00 0000000b
R 01 00000f80
R 05 0101401e
R 4b 000000ff
R 20 00000000
X 60 10
P 4 2 f80
P 5 3 f80
P 8 2 000
P 12 4 f80
P 14 4 000
P a d f80
P 4 11 000
P 28 a 000
P 24 1a f80
P 26 14 f80
P 2c 14 000
W 00 00000002
P 26 14 000
P 1e 14 f80
W 00 00000000
S 0
W 00 00000010
S 1
R 00 00000010

// ==== list.f ====
design/display_pkg.sv
design/sprite_pkg.sv
design/sprite_cfg_if.sv
design/display_timings.sv
design/sprite_regs.sv
design/sprite_engine.sv
design/starfield.sv
design/hello_display_top.sv
dv/hello_display_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator, verdict taken from the log
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module hello_display_tb -f list.f --Mdir "$BUILD_DIR" -o sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/sim" | tee "$LOG"
status=${PIPESTATUS[0]}
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Result: PASSED" "$LOG"; then
    echo "simulation passed, log in $LOG"
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi
